/* src/alu_ft_params.svh */
// fault tolerant ALU stage widths and redundancy constants
`default_nettype none

`ifndef ALU_FT_PARAMS_SVH
`define ALU_FT_PARAMS_SVH

// operand and result word
`define ALU_FT_DATA_WIDTH 32
// operator code
`define ALU_FT_OP_WIDTH 4

// three active replicas plus one cold spare
`define ALU_FT_NUM_REPLICAS 4
`define ALU_FT_NUM_SLOTS 3
`define ALU_FT_SPARE_IDX 3

// consecutive vote disagreements before a replica is retired
`define ALU_FT_FAULT_THRESH 3
// wide enough to hold the threshold
`define ALU_FT_CNT_WIDTH 2

`endif

`default_nettype wire

/* src/alu_ft_pkg.sv */
// fault tolerant ALU stage operator encoding and bus types
`include "alu_ft_params.svh"
`default_nettype none

package alu_ft_pkg;

	// one ALU data word
	typedef logic [`ALU_FT_DATA_WIDTH-1:0] alu_word_t;

	// operator codes
	// compare ops sit at the top of the encoding
	typedef enum logic [`ALU_FT_OP_WIDTH-1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_EQ,
		ALU_NE
	} alu_op_e;

	// request fanned out to every replica
	typedef struct packed {
		alu_op_e   operator;
		alu_word_t operand_a;
		alu_word_t operand_b;
	} alu_req_t;

	// replica or voted response
	typedef struct packed {
		alu_word_t result;
		logic      cmp;
	} alu_rsp_t;

	// per replica upset model
	// bits set here are flipped on the replica output
	typedef struct packed {
		alu_word_t res_mask;
		logic      cmp_flip;
	} alu_inject_t;

	// which physical replicas fill the three voting slots
	typedef enum logic [1:0] {
		SEL_BASE      = 2'd0,  // replicas 0 1 2
		SEL_REPLACE_0 = 2'd1,  // spare in slot 0
		SEL_REPLACE_1 = 2'd2,  // spare in slot 1
		SEL_REPLACE_2 = 2'd3   // spare in slot 2
	} alu_slot_sel_t;

endpackage : alu_ft_pkg

`default_nettype wire

/* src/alu_ft_alu.sv */
// single ALU replica with an output corruption hook for upset injection
`default_nettype none

module alu_ft_alu import alu_ft_pkg::*; (
	input  alu_req_t    req_i,
	input  alu_inject_t inject_i,
	output alu_rsp_t    rsp_o
);

	// fault free response
	alu_word_t  result;
	logic       cmp;
	// compare ops return cmp on the result word too
	logic       cmp_op;
	// only the low five bits shift
	logic [4:0] shamt;

	assign shamt  = req_i.operand_b[4:0];
	assign cmp_op = req_i.operator inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE};

	//////////////////////////////
	// operator datapath
	//////////////////////////////

	always_comb begin
		result = '0;
		cmp    = 1'b0;
		case (req_i.operator)
			ALU_ADD: begin
				result = req_i.operand_a + req_i.operand_b;
			end
			ALU_SUB: begin
				result = req_i.operand_a - req_i.operand_b;
			end
			ALU_AND: begin
				result = req_i.operand_a & req_i.operand_b;
			end
			ALU_OR: begin
				result = req_i.operand_a | req_i.operand_b;
			end
			ALU_XOR: begin
				result = req_i.operand_a ^ req_i.operand_b;
			end
			ALU_SLL: begin
				result = req_i.operand_a << shamt;
			end
			ALU_SRL: begin
				result = req_i.operand_a >> shamt;
			end
			ALU_SRA: begin
				// sign bit refills from the left
				result = $signed(req_i.operand_a) >>> shamt;
			end
			ALU_SLT: begin
				cmp = $signed(req_i.operand_a) < $signed(req_i.operand_b);
			end
			ALU_SLTU: begin
				cmp = req_i.operand_a < req_i.operand_b;
			end
			ALU_EQ: begin
				cmp = req_i.operand_a == req_i.operand_b;
			end
			ALU_NE: begin
				cmp = req_i.operand_a != req_i.operand_b;
			end
			default: begin
				// unused codes give zero
				result = '0;
			end
		endcase
		// zero extended flag for compares
		if (cmp_op) begin
			result = alu_word_t'(cmp);
		end
	end

	// upset model on the replica output
	assign rsp_o.result = result ^ inject_i.res_mask;
	assign rsp_o.cmp    = cmp ^ inject_i.cmp_flip;

endmodule : alu_ft_alu

`default_nettype wire

/* src/alu_ft_voter.sv */
// two out of three majority voter over a generic payload with mismatch report
`include "alu_ft_params.svh"
`default_nettype none

module alu_ft_voter import alu_ft_pkg::*; #(
	parameter type payload_t = alu_word_t
) (
	input  payload_t [`ALU_FT_NUM_SLOTS-1:0] in_i,
	output payload_t                         voted_o,
	output logic [`ALU_FT_NUM_SLOTS-1:0]     mismatch_o,
	output logic                             err_corrected_o,
	output logic                             err_detected_o
);

	// pairwise agreement
	logic eq_01;
	logic eq_02;
	logic eq_12;

	assign eq_01 = (in_i[0] == in_i[1]);
	assign eq_02 = (in_i[0] == in_i[2]);
	assign eq_12 = (in_i[1] == in_i[2]);

	always_comb begin
		// slot 0 wins unless it is the odd one out
		voted_o    = in_i[0];
		mismatch_o = '0;
		if (eq_01 && eq_02) begin
			// unanimous
			mismatch_o = 3'b000;
		end else if (eq_01) begin
			// slot 2 outvoted
			mismatch_o = 3'b100;
		end else if (eq_02) begin
			// slot 1 outvoted
			mismatch_o = 3'b010;
		end else if (eq_12) begin
			// slot 0 outvoted
			voted_o    = in_i[1];
			mismatch_o = 3'b001;
		end else begin
			// no majority
			// slot 0 passes through uncorrected
			mismatch_o = 3'b111;
		end
	end

	// any disagreement at all
	assign err_detected_o  = |mismatch_o;
	// masked only when a majority exists
	assign err_corrected_o = err_detected_o & ~(&mismatch_o);

endmodule : alu_ft_voter

`default_nettype wire

/* src/alu_ft_reconfig.sv */
// replica slot routing with per replica fault tracking and one shot spare swap
`include "alu_ft_params.svh"
`default_nettype none

module alu_ft_reconfig import alu_ft_pkg::*; (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 enable_i,
	input  alu_rsp_t [`ALU_FT_NUM_REPLICAS-1:0] rsp_i,
	input  logic [`ALU_FT_NUM_SLOTS-1:0]        mismatch_i,
	output alu_rsp_t [`ALU_FT_NUM_SLOTS-1:0]    slot_rsp_o,
	output logic [`ALU_FT_NUM_REPLICAS-1:0]     faulty_o,
	output logic [`ALU_FT_NUM_REPLICAS-1:0]     fault_event_o,
	output logic [`ALU_FT_NUM_REPLICAS-1:0]     clock_en_o
);

	localparam int unsigned idx_w = $clog2(`ALU_FT_NUM_REPLICAS);
	localparam logic [idx_w-1:0] spare_idx = idx_w'(`ALU_FT_SPARE_IDX);
	localparam logic [`ALU_FT_CNT_WIDTH-1:0] cnt_thresh =
		`ALU_FT_CNT_WIDTH'(`ALU_FT_FAULT_THRESH);

	// current slot selection
	alu_slot_sel_t sel_q;
	alu_slot_sel_t sel_d;
	// physical replica behind each slot
	logic [`ALU_FT_NUM_SLOTS-1:0][idx_w-1:0] slot_map;
	// slot view folded back onto replicas
	logic [`ALU_FT_NUM_REPLICAS-1:0] rep_active;
	logic [`ALU_FT_NUM_REPLICAS-1:0] rep_mismatch;
	// consecutive disagreement counters
	logic [`ALU_FT_NUM_REPLICAS-1:0][`ALU_FT_CNT_WIDTH-1:0] cnt_q;
	logic [`ALU_FT_NUM_REPLICAS-1:0][`ALU_FT_CNT_WIDTH-1:0] cnt_d;
	// sticky fault flags and their one cycle events
	logic [`ALU_FT_NUM_REPLICAS-1:0] faulty_q;
	logic [`ALU_FT_NUM_REPLICAS-1:0] faulty_d;
	logic [`ALU_FT_NUM_REPLICAS-1:0] event_q;
	logic [`ALU_FT_NUM_REPLICAS-1:0] event_d;

	//////////////////////////////
	// slot routing
	//////////////////////////////

	// slot s holds replica s unless the spare took it over
	always_comb begin
		for (int s = 0; s < `ALU_FT_NUM_SLOTS; s++) begin
			if (sel_q == alu_slot_sel_t'(s + 1)) begin
				slot_map[s] = spare_idx;
			end else begin
				slot_map[s] = idx_w'(s);
			end
		end
	end

	for (genvar s = 0; s < `ALU_FT_NUM_SLOTS; s++) begin : g_slot
		assign slot_rsp_o[s] = rsp_i[slot_map[s]];
	end

	// mismatch back to the physical unit
	always_comb begin
		rep_active   = '0;
		rep_mismatch = '0;
		for (int s = 0; s < `ALU_FT_NUM_SLOTS; s++) begin
			rep_active[slot_map[s]]   = 1'b1;
			rep_mismatch[slot_map[s]] = mismatch_i[s];
		end
	end

	// unused replica gets its clock gated
	assign clock_en_o = rep_active;

	//////////////////////////////
	// fault tracking
	//////////////////////////////

	always_comb begin
		cnt_d = cnt_q;
		for (int r = 0; r < `ALU_FT_NUM_REPLICAS; r++) begin
			// idle or parked replicas hold their count
			if (enable_i && rep_active[r]) begin
				if (!rep_mismatch[r]) begin
					cnt_d[r] = '0;
				end else if (cnt_q[r] != cnt_thresh) begin
					cnt_d[r] = cnt_q[r] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		faulty_d = faulty_q;
		for (int r = 0; r < `ALU_FT_NUM_REPLICAS; r++) begin
			if (cnt_d[r] == cnt_thresh) begin
				faulty_d[r] = 1'b1;
			end
		end
	end

	// pulse only on the first crossing
	assign event_d = faulty_d & ~faulty_q;

	// single swap from the base selection
	// lowest index wins so scan downwards
	always_comb begin
		sel_d = sel_q;
		if (sel_q == SEL_BASE) begin
			for (int r = `ALU_FT_NUM_SLOTS - 1; r >= 0; r--) begin
				if (faulty_d[r]) begin
					sel_d = alu_slot_sel_t'(r + 1);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sel_q    <= SEL_BASE;
			cnt_q    <= '0;
			faulty_q <= '0;
			event_q  <= '0;
		end else begin
			sel_q    <= sel_d;
			cnt_q    <= cnt_d;
			faulty_q <= faulty_d;
			event_q  <= event_d;
		end
	end

	assign faulty_o      = faulty_q;
	assign fault_event_o = event_q;

endmodule : alu_ft_reconfig

`default_nettype wire

/* src/alu_ft_top.sv */
// fault tolerant ALU stage with four replicas and voted registered output
`include "alu_ft_params.svh"
`default_nettype none

module alu_ft_top import alu_ft_pkg::*; (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  logic                                    enable_i,
	input  alu_req_t                                req_i,
	input  alu_inject_t [`ALU_FT_NUM_REPLICAS-1:0] inject_i,
	output logic                                    valid_o,
	output alu_rsp_t                                rsp_o,
	output logic                                    err_corrected_o,
	output logic                                    err_detected_o,
	output logic [`ALU_FT_NUM_REPLICAS-1:0]        faulty_o,
	output logic [`ALU_FT_NUM_REPLICAS-1:0]        fault_event_o,
	output logic [`ALU_FT_NUM_REPLICAS-1:0]        clock_en_o
);

	// replica outputs
	alu_rsp_t [`ALU_FT_NUM_REPLICAS-1:0] rep_rsp;
	// selected slot responses
	alu_rsp_t [`ALU_FT_NUM_SLOTS-1:0] slot_rsp;
	// split per voter
	alu_word_t [`ALU_FT_NUM_SLOTS-1:0] slot_res;
	logic [`ALU_FT_NUM_SLOTS-1:0]      slot_cmp;
	// voter results
	alu_word_t                    voted_res;
	logic                         voted_cmp;
	logic [`ALU_FT_NUM_SLOTS-1:0] mismatch_res;
	logic [`ALU_FT_NUM_SLOTS-1:0] mismatch_cmp;
	logic                         corrected_res;
	logic                         corrected_cmp;
	logic                         detected_res;
	logic                         detected_cmp;

	//////////////////////////////
	// replicas
	//////////////////////////////

	for (genvar r = 0; r < `ALU_FT_NUM_REPLICAS; r++) begin : g_replica
		alu_ft_alu i_alu (
			.req_i    ( req_i       ),
			.inject_i ( inject_i[r] ),
			.rsp_o    ( rep_rsp[r]  )
		);
	end

	// slot selection and fault bookkeeping
	alu_ft_reconfig i_reconfig (
		.clk           ( clk                         ),
		.rst_n_i       ( rst_n_i                     ),
		.enable_i      ( enable_i                    ),
		.rsp_i         ( rep_rsp                     ),
		.mismatch_i    ( mismatch_res | mismatch_cmp ),
		.slot_rsp_o    ( slot_rsp                    ),
		.faulty_o      ( faulty_o                    ),
		.fault_event_o ( fault_event_o               ),
		.clock_en_o    ( clock_en_o                  )
	);

	//////////////////////////////
	// voting
	//////////////////////////////

	for (genvar s = 0; s < `ALU_FT_NUM_SLOTS; s++) begin : g_split
		assign slot_res[s] = slot_rsp[s].result;
		assign slot_cmp[s] = slot_rsp[s].cmp;
	end

	// result word
	alu_ft_voter #(
		.payload_t ( alu_word_t )
	) i_voter_res (
		.in_i            ( slot_res      ),
		.voted_o         ( voted_res     ),
		.mismatch_o      ( mismatch_res  ),
		.err_corrected_o ( corrected_res ),
		.err_detected_o  ( detected_res  )
	);

	// comparison bit
	alu_ft_voter #(
		.payload_t ( logic )
	) i_voter_cmp (
		.in_i            ( slot_cmp      ),
		.voted_o         ( voted_cmp     ),
		.mismatch_o      ( mismatch_cmp  ),
		.err_corrected_o ( corrected_cmp ),
		.err_detected_o  ( detected_cmp  )
	);

	//////////////////////////////
	// output stage
	//////////////////////////////

	// strobe and flags only for accepted ops
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o         <= 1'b0;
			err_corrected_o <= 1'b0;
			err_detected_o  <= 1'b0;
		end else begin
			valid_o         <= enable_i;
			err_corrected_o <= enable_i & (corrected_res | corrected_cmp);
			err_detected_o  <= enable_i & (detected_res | detected_cmp);
		end
	end

	// voted payload
	always_ff @(posedge clk) begin
		if (enable_i) begin
			rsp_o.result <= voted_res;
			rsp_o.cmp    <= voted_cmp;
		end
	end

endmodule : alu_ft_top

`default_nettype wire

/* verification/alu_ft_checker.sv */
// scoreboard for the ALU stage with reference model of voting and fault tracking
`include "alu_ft_params.svh"
`default_nettype none

module alu_ft_checker import alu_ft_pkg::*; (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  logic                                    enable_i,
	input  alu_req_t                                req_i,
	input  alu_inject_t [`ALU_FT_NUM_REPLICAS-1:0] inject_i,
	input  logic                                    valid_i,
	input  alu_rsp_t                                rsp_i,
	input  logic                                    err_corrected_i,
	input  logic                                    err_detected_i,
	input  logic [`ALU_FT_NUM_REPLICAS-1:0]        faulty_i,
	input  logic [`ALU_FT_NUM_REPLICAS-1:0]        fault_event_i,
	input  logic [`ALU_FT_NUM_REPLICAS-1:0]        clock_en_i,
	output int unsigned                             check_cnt_o,
	output int unsigned                             error_cnt_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// outcome of one three way vote
	typedef struct packed {
		alu_word_t                    value;
		logic [`ALU_FT_NUM_SLOTS-1:0] mismatch;
		logic                         corrected;
		logic                         detected;
	} vote_t;

	// model state mirroring the registered DUT state
	int unsigned                     sel_m;
	int unsigned                     cnt_m [`ALU_FT_NUM_REPLICAS];
	logic [`ALU_FT_NUM_REPLICAS-1:0] faulty_m;
	logic [`ALU_FT_NUM_REPLICAS-1:0] faulty_old;
	logic [`ALU_FT_NUM_REPLICAS-1:0] event_m;
	logic [`ALU_FT_NUM_REPLICAS-1:0] en_m;
	logic                            valid_m;
	logic                            corr_m;
	logic                            det_m;
	alu_rsp_t                        rsp_m;
	// per cycle scratch
	alu_rsp_t    good;
	int unsigned slot [`ALU_FT_NUM_SLOTS];
	alu_word_t   res_s [`ALU_FT_NUM_SLOTS];
	alu_word_t   cmp_s [`ALU_FT_NUM_SLOTS];
	vote_t       vr;
	vote_t       vc;

	initial begin
		check_cnt_o = 0;
		error_cnt_o = 0;
	end

	// fault free result per operator
	function automatic alu_rsp_t alu_ref(input alu_req_t req);
		alu_rsp_t   rsp;
		logic [4:0] sh;
		sh  = req.operand_b[4:0];
		rsp = '0;
		case (req.operator)
			ALU_ADD:  rsp.result = req.operand_a + req.operand_b;
			ALU_SUB:  rsp.result = req.operand_a - req.operand_b;
			ALU_AND:  rsp.result = req.operand_a & req.operand_b;
			ALU_OR:   rsp.result = req.operand_a | req.operand_b;
			ALU_XOR:  rsp.result = req.operand_a ^ req.operand_b;
			ALU_SLL:  rsp.result = req.operand_a << sh;
			ALU_SRL:  rsp.result = req.operand_a >> sh;
			ALU_SRA:  rsp.result = $signed(req.operand_a) >>> sh;
			ALU_SLT:  rsp.cmp = $signed(req.operand_a) < $signed(req.operand_b);
			ALU_SLTU: rsp.cmp = req.operand_a < req.operand_b;
			ALU_EQ:   rsp.cmp = req.operand_a == req.operand_b;
			ALU_NE:   rsp.cmp = req.operand_a != req.operand_b;
			default:  rsp = '0;
		endcase
		// compares carry the flag in the low result bit
		if (req.operator >= ALU_SLT) begin
			rsp.result = alu_word_t'(rsp.cmp);
		end
		return rsp;
	endfunction

	// majority over three words with slot 0 winning a three way split
	function automatic vote_t vote3(input alu_word_t v0, input alu_word_t v1, input alu_word_t v2);
		vote_t v;
		v = '{value: v0, mismatch: 3'b000, corrected: 1'b0, detected: 1'b0};
		if (v0 != v1 || v0 != v2) begin
			v.detected  = 1'b1;
			v.corrected = 1'b1;
			if (v1 == v2) begin
				v.value    = v1;
				v.mismatch = 3'b001;
			end else if (v0 == v2) begin
				v.mismatch = 3'b010;
			end else if (v0 == v1) begin
				v.mismatch = 3'b100;
			end else begin
				v.mismatch  = 3'b111;
				v.corrected = 1'b0;
			end
		end
		return v;
	endfunction

	task automatic compare_value(input string name, input alu_word_t got, input alu_word_t exp);
		check_cnt_o++;
		if (got !== exp) begin
			error_cnt_o++;
			$display("[ERROR] %s: got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	always @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sel_m    = 0;
			faulty_m = '0;
			event_m  = '0;
			valid_m  = 1'b0;
			corr_m   = 1'b0;
			det_m    = 1'b0;
			for (int r = 0; r < `ALU_FT_NUM_REPLICAS; r++) begin
				cnt_m[r] = 0;
			end
		end else begin
			faulty_old = faulty_m;
			valid_m    = enable_i;
			corr_m     = 1'b0;
			det_m      = 1'b0;
			if (enable_i) begin
				good = alu_ref(req_i);
				// replicas behind each slot under the current selection
				for (int s = 0; s < `ALU_FT_NUM_SLOTS; s++) begin
					slot[s]  = (sel_m == s + 1) ? `ALU_FT_SPARE_IDX : s;
					res_s[s] = good.result ^ inject_i[slot[s]].res_mask;
					cmp_s[s] = alu_word_t'(good.cmp ^ inject_i[slot[s]].cmp_flip);
				end
				vr = vote3(res_s[0], res_s[1], res_s[2]);
				vc = vote3(cmp_s[0], cmp_s[1], cmp_s[2]);
				rsp_m.result = vr.value;
				rsp_m.cmp    = vc.value[0];
				corr_m       = vr.corrected | vc.corrected;
				det_m        = vr.detected | vc.detected;
				// consecutive disagreements saturating at the threshold
				for (int s = 0; s < `ALU_FT_NUM_SLOTS; s++) begin
					if (vr.mismatch[s] || vc.mismatch[s]) begin
						if (cnt_m[slot[s]] < `ALU_FT_FAULT_THRESH) begin
							cnt_m[slot[s]]++;
						end
					end else begin
						cnt_m[slot[s]] = 0;
					end
					if (cnt_m[slot[s]] == `ALU_FT_FAULT_THRESH) begin
						faulty_m[slot[s]] = 1'b1;
					end
				end
				// spare fills the first retired base slot only once
				for (int r = 0; r < `ALU_FT_NUM_SLOTS; r++) begin
					if (sel_m == 0 && faulty_m[r]) begin
						sel_m = r + 1;
					end
				end
			end
			event_m = faulty_m & ~faulty_old;
		end
	end

	//////////////////////////////
	// output compare
	//////////////////////////////

	// outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (rst_n_i === 1'b1) begin
			en_m = 4'b0111;
			if (sel_m != 0) begin
				en_m[sel_m - 1]          = 1'b0;
				en_m[`ALU_FT_SPARE_IDX] = 1'b1;
			end
			compare_value("valid_o", valid_i, valid_m);
			if (valid_m) begin
				compare_value("rsp_o.result", rsp_i.result, rsp_m.result);
				compare_value("rsp_o.cmp", rsp_i.cmp, rsp_m.cmp);
			end
			compare_value("err_corrected_o", err_corrected_i, corr_m);
			compare_value("err_detected_o", err_detected_i, det_m);
			compare_value("faulty_o", faulty_i, faulty_m);
			compare_value("fault_event_o", fault_event_i, event_m);
			compare_value("clock_en_o", clock_en_i, en_m);
		end
	end

endmodule : alu_ft_checker

`default_nettype wire

/* verification/alu_ft_props.sv */
// assertion monitor for clock enables, fault flags and error flags of the ALU stage
`include "alu_ft_params.svh"
`default_nettype none

module alu_ft_props (
	input logic                            clk,
	input logic                            rst_n_i,
	input logic                            err_corrected_o,
	input logic                            err_detected_o,
	input logic [`ALU_FT_NUM_REPLICAS-1:0] faulty_o,
	input logic [`ALU_FT_NUM_REPLICAS-1:0] fault_event_o,
	input logic [`ALU_FT_NUM_REPLICAS-1:0] clock_en_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// failed assertion count read by the testbench top
	int unsigned fail_cnt;

	initial begin
		fail_cnt = 0;
	end

	// one replica always parked
	a_three_enabled: assert property (@(posedge clk) disable iff (!rst_n_i)
		$countones(clock_en_o) == `ALU_FT_NUM_SLOTS)
	else begin
		fail_cnt++;
		$error("clock_en_o does not enable exactly three replicas");
	end

	// sticky until reset
	a_faulty_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
		(faulty_o & $past(faulty_o)) == $past(faulty_o))
	else begin
		fail_cnt++;
		$error("a faulty_o bit cleared without a reset");
	end

	a_event_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		(fault_event_o & $past(fault_event_o)) == '0)
	else begin
		fail_cnt++;
		$error("a fault_event_o bit stayed high for more than one cycle");
	end

	// a correction is always a detection too
	a_corr_implies_det: assert property (@(posedge clk) disable iff (!rst_n_i)
		err_corrected_o |-> err_detected_o)
	else begin
		fail_cnt++;
		$error("err_corrected_o set without err_detected_o");
	end

endmodule : alu_ft_props

bind alu_ft_top alu_ft_props i_alu_ft_props (.*);

`default_nettype wire

/* verification/alu_ft_tb.sv */
// testbench for the fault tolerant ALU stage with random and directed upset tests
`include "alu_ft_params.svh"
`default_nettype none

module alu_ft_tb import alu_ft_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned n_random_ops   = 200;
	// upset tests plus their clean tails
	localparam int unsigned n_directed_ops = 21;
	localparam int unsigned cycle_limit    = (n_random_ops + n_directed_ops) * 2 + 100;

	logic                                    clk;
	logic                                    rst_n;
	logic                                    enable;
	alu_req_t                                req;
	alu_inject_t [`ALU_FT_NUM_REPLICAS-1:0] inject;
	logic                                    valid;
	alu_rsp_t                                rsp;
	logic                                    err_corrected;
	logic                                    err_detected;
	logic [`ALU_FT_NUM_REPLICAS-1:0]        faulty;
	logic [`ALU_FT_NUM_REPLICAS-1:0]        fault_event;
	logic [`ALU_FT_NUM_REPLICAS-1:0]        clock_en;
	int unsigned                             check_cnt;
	int unsigned                             error_cnt;
	int unsigned                             errors_before;
	int unsigned                             cycle_cnt;

	alu_ft_top i_alu_ft_top (
		.clk             ( clk           ),
		.rst_n_i         ( rst_n         ),
		.enable_i        ( enable        ),
		.req_i           ( req           ),
		.inject_i        ( inject        ),
		.valid_o         ( valid         ),
		.rsp_o           ( rsp           ),
		.err_corrected_o ( err_corrected ),
		.err_detected_o  ( err_detected  ),
		.faulty_o        ( faulty        ),
		.fault_event_o   ( fault_event   ),
		.clock_en_o      ( clock_en      )
	);

	alu_ft_checker i_alu_ft_checker (
		.clk             ( clk           ),
		.rst_n_i         ( rst_n         ),
		.enable_i        ( enable        ),
		.req_i           ( req           ),
		.inject_i        ( inject        ),
		.valid_i         ( valid         ),
		.rsp_i           ( rsp           ),
		.err_corrected_i ( err_corrected ),
		.err_detected_i  ( err_detected  ),
		.faulty_i        ( faulty        ),
		.fault_event_i   ( fault_event   ),
		.clock_en_i      ( clock_en      ),
		.check_cnt_o     ( check_cnt     ),
		.error_cnt_o     ( error_cnt     )
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// scoreboard mismatches plus failed assertions
	function automatic int unsigned total_errors();
		return error_cnt + i_alu_ft_top.i_alu_ft_props.fail_cnt;
	endfunction

	function automatic alu_req_t random_req();
		alu_req_t r;
		r.operator  = alu_op_e'($urandom_range(11, 0));
		r.operand_a = $urandom;
		r.operand_b = $urandom;
		// equal operands now and then for EQ and NE
		if ($urandom_range(3, 0) == 0) begin
			r.operand_b = r.operand_a;
		end
		return r;
	endfunction

	task automatic do_reset();
		@(negedge clk);
		rst_n  = 1'b0;
		enable = 1'b0;
		inject = '0;
		repeat (4) begin
			@(negedge clk);
		end
		rst_n = 1'b1;
	endtask

	task automatic issue_op(input alu_req_t r, input alu_inject_t [`ALU_FT_NUM_REPLICAS-1:0] inj);
		@(negedge clk);
		enable = 1'b1;
		req    = r;
		inject = inj;
	endtask

	// drain the last op then print one line for the test
	task automatic report_test(input string name);
		int unsigned errs;
		@(negedge clk);
		enable = 1'b0;
		inject = '0;
		@(posedge clk);
		// assertion actions of this edge settle first
		#1;
		errs = total_errors() - errors_before;
		$display("test %-24s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
		errors_before = total_errors();
	endtask

	initial begin
		alu_req_t                                r;
		alu_inject_t [`ALU_FT_NUM_REPLICAS-1:0] inj;
		alu_word_t                               mask;
		void'($urandom(79));
		rst_n         = 1'b0;
		enable        = 1'b0;
		req           = '0;
		inject        = '0;
		errors_before = 0;
		do_reset();

		repeat (n_random_ops) begin
			issue_op(random_req(), '0);
		end
		report_test("random clean ops");

		// one transient upset on replica 1
		inj             = '0;
		inj[1].res_mask = $urandom | 32'h1;
		issue_op(random_req(), inj);
		issue_op(random_req(), '0);
		report_test("single upset");

		// replicas 0 and 2 disagree with each other and with 1
		inj             = '0;
		mask            = ($urandom | 32'h1) & ~32'h2;
		inj[0].res_mask = mask;
		inj[2].res_mask = ~mask;
		r               = random_req();
		r.operator      = ALU_ADD;
		issue_op(r, inj);
		inj[0].cmp_flip = 1'b1;
		r.operator      = ALU_SLTU;
		issue_op(r, inj);
		// clean ops clear the counters again
		repeat (3) begin
			issue_op(random_req(), '0);
		end
		report_test("double upset");

		// persistent fault retires replica 1 and the spare takes slot 1
		inj             = '0;
		inj[1].res_mask = $urandom | 32'h1;
		repeat (`ALU_FT_FAULT_THRESH + 4) begin
			issue_op(random_req(), inj);
		end
		report_test("replica 1 swap");

		// replica 0 fails too without a second swap
		inj[0].res_mask = $urandom | 32'h1;
		repeat (`ALU_FT_FAULT_THRESH + 2) begin
			issue_op(random_req(), inj);
		end
		do_reset();
		repeat (2) begin
			issue_op(random_req(), '0);
		end
		report_test("second fault and reset");

		$display("checks %0d, errors %0d", check_cnt, total_errors());
		if (total_errors() == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// run length guard
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the test sequence did not finish within %0d cycles", cycle_limit);
		$display("Finished with errors");
		$finish;
	end

endmodule : alu_ft_tb

`default_nettype wire

/* sim.f */
+incdir+src
src/alu_ft_pkg.sv
src/alu_ft_alu.sv
src/alu_ft_voter.sv
src/alu_ft_reconfig.sv
src/alu_ft_top.sv
verification/alu_ft_checker.sv
verification/alu_ft_props.sv
verification/alu_ft_tb.sv

/* Bender.yml */
package:
  name: alu_ft

sources:
  - include_dirs:
      - src
    files:
      - src/alu_ft_pkg.sv
      - src/alu_ft_alu.sv
      - src/alu_ft_voter.sv
      - src/alu_ft_reconfig.sv
      - src/alu_ft_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/alu_ft_checker.sv
      - verification/alu_ft_props.sv
      - verification/alu_ft_tb.sv
